//--- dv/dsp_xor_bank_tb.sv
`timescale 1ns/1ps

module dsp_xor_bank_tb;
    logic                  clock;
    logic                  arst_n;
    dsp_xor_pkg::apb_req_t apb_req;
    dsp_xor_pkg::apb_rsp_t apb_rsp;
    dsp_xor_pkg::word_t    opnd [dsp_xor_pkg::operand_count];   // shadow of operand regs
    dsp_xor_pkg::word_t    res_exp [dsp_xor_pkg::result_count]; // model results, index 2n + k
    logic [7:0]            zf_exp;                              // predicted zero flags
    dsp_xor_pkg::alumode_t mode_now;
    logic [31:0]           rng;                                 // xorshift state
    int                    error_count;
    int                    cycle_count = 0;

    tb_clock_gen tb_clock_gen_inst (
        .clock (clock)
    );

    dsp_xor_bank dsp_xor_bank_inst (
        .clock   (clock),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    // bus never waits
    assert property (@(posedge clock) disable iff (!arst_n) apb_rsp.pready)
        else begin
            error_count++;
            $display("%0t ns: pready went low", $time);
        end

    // no error response outside an access phase
    assert property (@(posedge clock) disable iff (!arst_n)
                     !(apb_req.psel && apb_req.penable) |-> !apb_rsp.pslverr)
        else begin
            error_count++;
            $display("%0t ns: pslverr raised outside an access phase", $time);
        end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // logic unit rule, one 24-bit half
    function automatic dsp_xor_pkg::word_t model_result(input dsp_xor_pkg::alumode_t m,
                                                        input dsp_xor_pkg::word_t a,
                                                        input dsp_xor_pkg::word_t b);
        dsp_xor_pkg::word_t y;
        case (m)
            dsp_xor_pkg::alumode_xnor: y = ~(a ^ b);   // 24-bit type keeps it in range
            dsp_xor_pkg::alumode_and:  y = a & b;
            dsp_xor_pkg::alumode_or:   y = a | b;
            default:                   y = a ^ b;
        endcase
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            error_count++;
            $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // setup on one falling edge, access on the next, completes at the rising edge after
    task automatic bus_transfer(input logic [7:0] addr, input logic write,
                                input logic [31:0] wdata, input logic exp_err,
                                output logic [31:0] data);
        @(negedge clock);
        apb_req.paddr   = addr;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        @(negedge clock);
        apb_req.penable = 1'b1;
        #1;                                  // response settled, well before the edge
        data = apb_rsp.prdata;
        check_value($sformatf("pslverr @%h", addr), {31'd0, exp_err}, {31'd0, apb_rsp.pslverr});
        @(posedge clock);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata,
                             input logic exp_err);
        logic [31:0] unused;
        bus_transfer(addr, 1'b1, wdata, exp_err, unused);
    endtask

    task automatic read_expect(input string name, input logic [7:0] addr,
                               input logic [31:0] exp);
        logic [31:0] data;
        bus_transfer(addr, 1'b0, '0, 1'b0, data);
        check_value(name, exp, data);
    endtask

    task automatic bus_idle();
        @(negedge clock);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic load_random_operands();
        for (int i = 0; i < dsp_xor_pkg::operand_count; i++) begin
            rng     = xorshift(rng);
            opnd[i] = rng[23:0];
            write_reg(8'(4 * i), rng, 1'b0);    // random upper byte must be dropped
        end
    endtask

    task automatic set_mode(input dsp_xor_pkg::alumode_t m);
        mode_now = m;
        write_reg(dsp_xor_pkg::addr_mode, {28'd0, m}, 1'b0);
        read_expect("mode", dsp_xor_pkg::addr_mode, {28'd0, m});
    endtask

    task automatic predict();
        for (int i = 0; i < dsp_xor_pkg::result_count; i++) begin
            res_exp[i] = model_result(mode_now, opnd[2*i], opnd[2*i+1]);  // a at 4n+2k, b next
            zf_exp[i]  = (res_exp[i] == '0);
        end
    endtask

    task automatic check_results();
        for (int i = 0; i < dsp_xor_pkg::result_count; i++) begin
            read_expect($sformatf("lane %0d y%0d", i / 2, i % 2),
                        8'(dsp_xor_pkg::addr_result_base + 4 * i), {8'd0, res_exp[i]});
        end
    endtask

    // go, then busy on the next transfer and done on the one after
    task automatic launch_and_check();
        logic [31:0] data;
        predict();
        write_reg(dsp_xor_pkg::addr_ctrl, 32'd1, 1'b0);
        bus_transfer(dsp_xor_pkg::addr_status, 1'b0, '0, 1'b0, data);
        check_value("status busy/done", 32'd2, {30'd0, data[1:0]});
        read_expect("status", dsp_xor_pkg::addr_status, {16'd0, zf_exp, 8'h01});
        check_results();
    endtask

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= 4000) begin            // roughly ten times the sequence length
            $display("run stopped: cycle limit reached, errors: %0d", error_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        dsp_xor_pkg::alumode_t modes [3];
        logic [31:0]           hole_data;        // read data of the unmapped access
        modes       = '{dsp_xor_pkg::alumode_xnor, dsp_xor_pkg::alumode_and,
                        dsp_xor_pkg::alumode_or};
        error_count = 0;
        arst_n      = 1'b0;
        apb_req     = '0;
        rng         = 32'd28673;
        mode_now    = dsp_xor_pkg::alumode_xor;
        zf_exp      = '0;
        for (int i = 0; i < dsp_xor_pkg::operand_count; i++) begin
            opnd[i] = '0;
        end
        for (int i = 0; i < dsp_xor_pkg::result_count; i++) begin
            res_exp[i] = '0;
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        read_expect("status", dsp_xor_pkg::addr_status, 32'd0);       // reset state
        read_expect("mode", dsp_xor_pkg::addr_mode, {28'd0, dsp_xor_pkg::alumode_xor});
        check_results();

        load_random_operands();                  // default xor
        launch_and_check();

        foreach (modes[m]) begin
            set_mode(modes[m]);
            load_random_operands();
            launch_and_check();
        end

        set_mode(dsp_xor_pkg::alumode_xor);      // lane 2 y0 forced to zero
        load_random_operands();
        opnd[9] = opnd[8];
        write_reg(8'h24, {8'd0, opnd[9]}, 1'b0);
        launch_and_check();

        bus_transfer(8'h90, 1'b0, '0, 1'b1, hole_data);   // hole in the map
        write_reg(8'h90, 32'hdead_beef, 1'b1);
        write_reg(8'h44, 32'h00ff_ffff, 1'b1);   // read-only result
        read_expect("lane 0 y1", 8'h44, {8'd0, res_exp[1]});
        write_reg(dsp_xor_pkg::addr_status, 32'hffff_ffff, 1'b1);
        read_expect("status", dsp_xor_pkg::addr_status, {16'd0, zf_exp, 8'h01});
        write_reg(8'h3c, 32'hff5a_c3e1, 1'b0);   // upper byte ignored
        opnd[15] = 24'h5a_c3e1;
        read_expect("lane 3 b1", 8'h3c, 32'h005a_c3e1);

        load_random_operands();                  // go refused while busy
        predict();
        write_reg(dsp_xor_pkg::addr_ctrl, 32'd1, 1'b0);
        write_reg(dsp_xor_pkg::addr_ctrl, 32'd1, 1'b1);
        read_expect("status", dsp_xor_pkg::addr_status, {16'd0, zf_exp, 8'h01});
        check_results();
        bus_idle();

        $display("errors: %0d, cycles: %0d", error_count, cycle_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock
);
    initial begin
        clock = 1'b0;
    end

    always begin
        #20 clock = ~clock;    // 40 ns period
    end

endmodule

//--- hw/apb_operand_regs.sv
`timescale 1ns/1ps

module apb_operand_regs (
    input  logic                                   clock,
    input  logic                                   arst_n,
    input  dsp_xor_pkg::apb_req_t                  apb_req,
    output dsp_xor_pkg::apb_rsp_t                  apb_rsp,
    output dsp_xor_pkg::lane_op_t                  lane_op [dsp_xor_pkg::lane_count],
    input  dsp_xor_pkg::word_t                     results [dsp_xor_pkg::result_count],
    input  logic [dsp_xor_pkg::result_count-1:0]   zero_flags,
    input  dsp_xor_pkg::collector_state_t          state
);
    dsp_xor_pkg::apb_addr_t addr;
    dsp_xor_pkg::apb_data_t rdata;
    dsp_xor_pkg::word_t     operands [dsp_xor_pkg::operand_count];
    dsp_xor_pkg::alumode_t  mode;
    logic                   access;      // access phase, completes at next edge
    logic                   wr;
    logic                   busy;
    logic                   is_operand;
    logic                   is_result;
    logic                   is_ctrl;
    logic                   is_mode;
    logic                   is_status;
    logic                   mapped;
    logic [3:0]             opnd_idx;    // lane in 3:2, word in 1:0
    logic [2:0]             res_idx;     // lane in 2:1, half in 0
    logic                   go_req;
    logic                   err;
    logic                   launch;      // registered go, feeds lane valid

    assign addr   = apb_req.paddr;
    assign access = apb_req.psel & apb_req.penable;
    assign wr     = access & apb_req.pwrite;
    assign busy   = (state == dsp_xor_pkg::coll_busy);

    // operand window 0x00-0x3c, result window 0x40-0x5c, word aligned only
    assign is_operand = (addr[7:6] == dsp_xor_pkg::addr_operand_base[7:6]) && (addr[1:0] == 2'b00);
    assign is_result  = (addr[7:5] == dsp_xor_pkg::addr_result_base[7:5]) && (addr[1:0] == 2'b00);
    assign is_ctrl    = (addr == dsp_xor_pkg::addr_ctrl);
    assign is_mode    = (addr == dsp_xor_pkg::addr_mode);
    assign is_status  = (addr == dsp_xor_pkg::addr_status);
    assign mapped     = is_operand | is_result | is_ctrl | is_mode | is_status;
    assign opnd_idx   = addr[5:2];
    assign res_idx    = addr[4:2];

    assign go_req = wr & is_ctrl & apb_req.pwdata[0];   // ctrl write without go is harmless

    always_comb begin
        err = 1'b0;
        if (access) begin
            if (!mapped) begin
                err = 1'b1;                                   // hole in the map
            end else if (apb_req.pwrite && (is_result || is_status)) begin
                err = 1'b1;                                   // read-only registers
            end else if (busy && (go_req || (wr && is_mode))) begin
                err = 1'b1;                                   // lanes still in flight
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < dsp_xor_pkg::operand_count; i++) begin
                operands[i] <= '0;
            end
            mode   <= dsp_xor_pkg::alumode_xor;
            launch <= 1'b0;
        end else begin
            launch <= go_req & ~err;                           // single-cycle pulse
            if (wr && !err && is_operand) begin
                operands[opnd_idx] <= apb_req.pwdata[dsp_xor_pkg::word_width-1:0];  // 31:24 dropped
            end
            if (wr && !err && is_mode) begin
                mode <= apb_req.pwdata[3:0];
            end
        end
    end

    always_comb begin
        rdata = '0;                                            // zero-extend everything
        if (is_operand) begin
            rdata[dsp_xor_pkg::word_width-1:0] = operands[opnd_idx];
        end else if (is_result) begin
            rdata[dsp_xor_pkg::word_width-1:0] = results[res_idx];
        end else if (is_mode) begin
            rdata[3:0] = mode;
        end else if (is_status) begin
            rdata[0]    = (state == dsp_xor_pkg::coll_done);
            rdata[1]    = busy;
            rdata[15:8] = zero_flags;                          // bit 8 + 2n + k
        end
    end

    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : '0;
    assign apb_rsp.pready  = 1'b1;                             // zero wait state
    assign apb_rsp.pslverr = err;

    // operands broadcast straight from storage, launch qualifies them
    for (genvar n = 0; n < dsp_xor_pkg::lane_count; n++) begin : g_lane_op
        assign lane_op[n].a0      = operands[4*n+0];
        assign lane_op[n].b0      = operands[4*n+1];
        assign lane_op[n].a1      = operands[4*n+2];
        assign lane_op[n].b1      = operands[4*n+3];
        assign lane_op[n].alumode = mode;
        assign lane_op[n].valid   = launch;                    // all lanes start together
    end

endmodule

//--- hw/dsp_xor_bank.sv
`timescale 1ns/1ps

module dsp_xor_bank (
    input  logic                  clock,
    input  logic                  arst_n,
    input  dsp_xor_pkg::apb_req_t apb_req,
    output dsp_xor_pkg::apb_rsp_t apb_rsp
);
    dsp_xor_pkg::lane_op_t                lane_op [dsp_xor_pkg::lane_count];   // regs to lanes
    dsp_xor_pkg::lane_res_t               lane_res [dsp_xor_pkg::lane_count];  // lanes to collector
    dsp_xor_pkg::word_t                   results [dsp_xor_pkg::result_count];
    logic [dsp_xor_pkg::result_count-1:0] zero_flags;
    dsp_xor_pkg::collector_state_t        state;

    apb_operand_regs apb_operand_regs_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .lane_op    (lane_op),
        .results    (results),
        .zero_flags (zero_flags),
        .state      (state)
    );

    // four slices side by side, all fed by the same launch
    for (genvar n = 0; n < dsp_xor_pkg::lane_count; n++) begin : g_lane
        dsp_xor_lane dsp_xor_lane_inst (
            .clock  (clock),
            .arst_n (arst_n),
            .op     (lane_op[n]),
            .res    (lane_res[n])
        );
    end

    result_collector result_collector_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .start      (lane_op[0].valid),   // valid is common to every lane
        .lane_res   (lane_res),
        .results    (results),
        .zero_flags (zero_flags),
        .state      (state)
    );

endmodule

//--- hw/dsp_xor_lane.sv
`timescale 1ns/1ps

module dsp_xor_lane (
    input  logic                   clock,
    input  logic                   arst_n,
    input  dsp_xor_pkg::lane_op_t  op,
    output dsp_xor_pkg::lane_res_t res
);
    dsp_xor_pkg::dsp_word_t dsp_c;      // z mux source
    dsp_xor_pkg::dsp_word_t dsp_ab;     // x mux source, a is 47:18 and b is 17:0
    dsp_xor_pkg::dsp_word_t p_next;
    dsp_xor_pkg::dsp_word_t p_reg;      // preg=1
    logic                   valid_reg;

    assign dsp_c  = {op.a1, op.a0};
    assign dsp_ab = {op.b1, op.b0};

    // logic unit has no carries, so 48-bit ops split cleanly into two24 halves
    always_comb begin
        case (op.alumode)
            dsp_xor_pkg::alumode_xor: begin
                p_next = dsp_ab ^ dsp_c;
            end
            dsp_xor_pkg::alumode_xnor: begin
                p_next = ~(dsp_ab ^ dsp_c);
            end
            dsp_xor_pkg::alumode_and: begin
                p_next = dsp_ab & dsp_c;
            end
            dsp_xor_pkg::alumode_or: begin
                p_next = dsp_ab | dsp_c;
            end
            default: begin
                p_next = dsp_ab ^ dsp_c;     // unknown code falls back to xor
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (op.valid) begin
            p_reg <= p_next;                 // cep tied to launch
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_reg <= 1'b0;
        end else begin
            valid_reg <= op.valid;           // follows p by the same edge
        end
    end

    assign res.y0    = p_reg[dsp_xor_pkg::word_width-1:0];
    assign res.y1    = p_reg[2*dsp_xor_pkg::word_width-1:dsp_xor_pkg::word_width];
    assign res.valid = valid_reg;

endmodule

//--- hw/dsp_xor_pkg.sv
package dsp_xor_pkg;

    localparam int lane_count     = 4;                       // lanes in the bank
    localparam int simd_ways      = 2;                       // two24 simd, two results per lane
    localparam int word_width     = 24;                      // one simd half of the slice
    localparam int apb_addr_width = 8;
    localparam int apb_data_width = 32;
    localparam int result_count   = lane_count * simd_ways;  // y0/y1 of every lane
    localparam int operand_count  = result_count * 2;        // a and b per result

    typedef logic [word_width-1:0]           word_t;      // one operand or result
    typedef logic [simd_ways*word_width-1:0] dsp_word_t;  // full 48-bit c or a:b bus
    typedef logic [3:0]                      alumode_t;   // slice alumode field
    typedef logic [apb_addr_width-1:0]       apb_addr_t;
    typedef logic [apb_data_width-1:0]       apb_data_t;

    // logic-unit codes, x = a:b and z = c
    localparam alumode_t alumode_xor  = 4'b0100;  // x xor z
    localparam alumode_t alumode_xnor = 4'b0101;  // x xnor z
    localparam alumode_t alumode_and  = 4'b1100;  // x and z
    localparam alumode_t alumode_or   = 4'b1000;  // slice does or as 1100 with opmode[3:2]=10

    localparam apb_addr_t addr_operand_base = 8'h00;  // lane n at 0x10*n, a0 b0 a1 b1
    localparam apb_addr_t addr_result_base  = 8'h40;  // lane n at 0x40 + 8*n, y0 y1
    localparam apb_addr_t addr_ctrl         = 8'h80;  // bit 0 go
    localparam apb_addr_t addr_mode         = 8'h84;  // alumode in 3:0
    localparam apb_addr_t addr_status       = 8'h88;  // done, busy, zero flags 15:8

    typedef struct packed {
        apb_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        word_t    a0;
        word_t    b0;
        word_t    a1;
        word_t    b1;
        alumode_t alumode;
        logic     valid;    // one-cycle launch pulse
    } lane_op_t;

    typedef struct packed {
        word_t y0;
        word_t y1;
        logic  valid;       // p register loaded
    } lane_res_t;

    typedef enum logic [1:0] {
        coll_idle,
        coll_busy,
        coll_done
    } collector_state_t;

endpackage

//--- hw/result_collector.sv
`timescale 1ns/1ps

module result_collector (
    input  logic                                 clock,
    input  logic                                 arst_n,
    input  logic                                 start,       // lane launch pulse
    input  dsp_xor_pkg::lane_res_t               lane_res [dsp_xor_pkg::lane_count],
    output dsp_xor_pkg::word_t                   results [dsp_xor_pkg::result_count],
    output logic [dsp_xor_pkg::result_count-1:0] zero_flags,
    output dsp_xor_pkg::collector_state_t        state
);
    dsp_xor_pkg::collector_state_t state_next;
    dsp_xor_pkg::word_t            lane_words [dsp_xor_pkg::result_count];  // flattened y0/y1
    logic                          all_valid;
    logic                          capture;

    always_comb begin
        all_valid = 1'b1;
        for (int n = 0; n < dsp_xor_pkg::lane_count; n++) begin
            all_valid         = all_valid & lane_res[n].valid;
            lane_words[2*n]   = lane_res[n].y0;
            lane_words[2*n+1] = lane_res[n].y1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            dsp_xor_pkg::coll_idle: begin
                if (start) begin
                    state_next = dsp_xor_pkg::coll_busy;
                end
            end
            dsp_xor_pkg::coll_busy: begin
                if (all_valid) begin
                    state_next = dsp_xor_pkg::coll_done;   // every lane has its p loaded
                end
            end
            dsp_xor_pkg::coll_done: begin
                if (start) begin
                    state_next = dsp_xor_pkg::coll_busy;   // relaunch clears done
                end
            end
            default: begin
                state_next = dsp_xor_pkg::coll_idle;
            end
        endcase
    end

    assign capture = (state == dsp_xor_pkg::coll_busy) && all_valid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= dsp_xor_pkg::coll_idle;
        end else begin
            state <= state_next;
        end
    end

    // results and flags held until the next capture
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < dsp_xor_pkg::result_count; i++) begin
                results[i] <= '0;
            end
            zero_flags <= '0;
        end else if (capture) begin
            for (int i = 0; i < dsp_xor_pkg::result_count; i++) begin
                results[i]    <= lane_words[i];
                zero_flags[i] <= (lane_words[i] == '0);   // index 2n + k
            end
        end
    end

endmodule

//--- sources.f
hw/dsp_xor_pkg.sv
hw/apb_operand_regs.sv
hw/dsp_xor_lane.sv
hw/result_collector.sv
hw/dsp_xor_bank.sv
dv/tb_clock_gen.sv
dv/dsp_xor_bank_tb.sv
